// File: Makefile
VERILATOR  := verilator
TOP        := tb_data_io
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
+incdir+verif
source/dl_pkg.sv
source/spi_rx_if.sv
source/spi_shifter.sv
source/spi_frame_tracker.sv
source/download_engine.sv
source/data_io_top.sv
verif/tb_data_io.sv

// File: source/data_io_top.sv
// download port top level with spi bit shifter, frame tracker and system side engine

`timescale 1ns/1ps

module data_io_top import dl_pkg::*; (
	// system clock and reset
	input  logic      sck,
	input  logic      ss,

	// serial link from the spi host
	input  logic      spi_clk,
	input  logic      spi_cs,
	input  logic      spi_mosi,

	// download status
	output logic      downloading,
	output addr_t     size,

	// ram write port
	output logic      wr,
	output addr_t     a,
	output lane_sel_t sel,
	output ram_word_t d
);

	// bytes and frame state on their way to the system clock
	spi_rx_if rx_if ();

	// ************************************************************************
	// spi clock domain
	// ************************************************************************

	// both parts see the same serial stream
	// the tracker takes its bit position from the shifter
	spi_shifter u_shifter (
		.spi_clk  (spi_clk),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.rx       (rx_if.shifter_mp)
	);

	spi_frame_tracker u_tracker (
		.spi_clk  (spi_clk),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.rx       (rx_if.tracker_mp)
	);

	// ************************************************************************
	// system clock domain
	// ************************************************************************

	download_engine u_engine (
		.sck         (sck),
		.ss          (ss),
		.rx          (rx_if.engine_mp),
		.downloading (downloading),
		.size        (size),
		.wr          (wr),
		.a           (a),
		.sel         (sel),
		.d           (d)
	);

endmodule

// File: source/dl_pkg.sv
// download port package with address width, start address, host command codes and shared types

package dl_pkg;

	// ************************************************************************
	// sizes
	// ************************************************************************

	// byte address width of the target ram
	localparam int ADDR_WIDTH = 24;

	// ************************************************************************
	// types
	// ************************************************************************

	// one byte as it comes off the serial line
	typedef logic [7:0] byte_t;

	// byte address into the ram
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// one-hot byte lane enable of a 32 bit word
	typedef logic [3:0] lane_sel_t;

	// ram data word, four byte lanes
	typedef logic [31:0] ram_word_t;

	// ************************************************************************
	// constants
	// ************************************************************************

	// first byte address written by a download
	localparam addr_t START_ADDR = '0;

	// host commands
	// file transfer control, argument != 0 starts and 0 ends a download
	localparam byte_t CMD_FILE_TX = 8'h53;
	// file transfer data, every following byte of the frame is stored
	localparam byte_t CMD_FILE_TX_DAT = 8'h54;

endpackage

// File: source/download_engine.sv
// system clock download engine with crossing synchronizers, command decode, address counter and ram write port

`timescale 1ns/1ps

module download_engine import dl_pkg::*; (
	input  logic      sck,
	input  logic      ss,
	spi_rx_if.engine_mp rx,
	output logic      downloading,
	output addr_t     size,
	output logic      wr,
	output addr_t     a,
	output lane_sel_t sel,
	output ram_word_t d
);

	// ************************************************************************
	// clock domain crossing
	// ************************************************************************

	// two sync stages plus one delayed copy each
	logic [2:0] tog_sync;
	logic [2:0] open_sync;

	// byte strobe seen in the system domain
	logic new_byte;
	// synchronized frame_open just fell
	logic frame_end;
	// new byte that follows the command byte
	logic byte_ok;

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			tog_sync  <= '0;
			open_sync <= '0;
		end else begin
			tog_sync  <= {tog_sync[1:0], rx.rx_toggle};
			open_sync <= {open_sync[1:0], rx.frame_open};
		end
	end

	// any change of the toggle is a byte
	assign new_byte  = tog_sync[2] ^ tog_sync[1];
	assign frame_end = open_sync[2] & ~open_sync[1];

	// rx_byte, rx_cmd and rx_payload are stable here
	// they only move with the toggle and hold for eight spi_clk periods
	assign byte_ok = new_byte & rx.rx_payload;

	// ************************************************************************
	// command decode and address counter
	// ************************************************************************

	// next free byte address
	addr_t addr;
	// control argument already taken in this frame
	logic  arg_taken;
	// last data byte, goes out on every lane
	byte_t data_q;

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			wr          <= 1'b0;
			downloading <= 1'b0;
			a           <= '0;
			addr        <= START_ADDR;
			arg_taken   <= 1'b0;
		end else begin
			// write strobe is a single cycle pulse
			wr <= 1'b0;

			// next control frame may act again
			if (frame_end) begin
				arg_taken <= 1'b0;
			end

			if (byte_ok) begin
				case (rx.rx_cmd)
					CMD_FILE_TX: begin
						// only the first argument byte of a control frame counts
						if (!arg_taken) begin
							arg_taken <= 1'b1;
							if (rx.rx_byte != 8'h00) begin
								// start, rewind to the first address
								addr        <= START_ADDR;
								downloading <= 1'b1;
							end else begin
								// end, leave a at the next free address
								a           <= addr;
								downloading <= 1'b0;
							end
						end
					end
					CMD_FILE_TX_DAT: begin
						a    <= addr;
						addr <= addr + 1'b1;
						wr   <= 1'b1;
					end
					default: begin
						// other host commands are not handled here
					end
				endcase
			end
		end
	end

	// payload register, only valid together with wr
	always_ff @(posedge sck) begin
		if (byte_ok && (rx.rx_cmd == CMD_FILE_TX_DAT)) begin
			data_q <= rx.rx_byte;
		end
	end

	// ************************************************************************
	// ram side outputs
	// ************************************************************************

	// lane enable from the low address bits
	assign sel = 4'b0001 << a[1:0];

	// the ram picks the lane through sel
	assign d = {4{data_q}};

	// bytes written since the last start
	assign size = addr - START_ADDR;

endmodule

// File: source/spi_frame_tracker.sv
// spi frame tracker with byte counter, command byte capture, payload flag and frame open state

`timescale 1ns/1ps

module spi_frame_tracker import dl_pkg::*; (
	input logic spi_clk,
	input logic spi_cs,
	input logic spi_mosi,
	spi_rx_if.tracker_mp rx
);

	// completed bytes in this frame, stops at the top value
	logic [2:0] byte_cnt;
	// first seven bits of the command byte
	logic [6:0] cmd_sreg;
	logic first_byte;

	// still inside the command byte
	assign first_byte = (byte_cnt == 3'd0);

	// ************************************************************************
	// frame state
	// ************************************************************************

	always_ff @(posedge spi_clk or posedge spi_cs) begin
		if (spi_cs) begin
			byte_cnt      <= '0;
			rx.rx_payload <= 1'b0;
			rx.frame_open <= 1'b0;
		end else begin
			// open from the first clock of the frame
			rx.frame_open <= 1'b1;
			if (rx.bit_last) begin
				// saturate so long data frames never wrap back to command
				if (byte_cnt != 3'd7) begin
					byte_cnt <= byte_cnt + 3'd1;
				end
				// flag describes the byte finishing on this edge
				rx.rx_payload <= !first_byte;
			end
		end
	end

	// ************************************************************************
	// command byte
	// ************************************************************************

	// own shift path only during the first byte
	// the bit position comes from the shifter
	always_ff @(posedge spi_clk) begin
		if (first_byte) begin
			if (rx.bit_last) begin
				rx.rx_cmd <= {cmd_sreg, spi_mosi};
			end else begin
				cmd_sreg <= {cmd_sreg[5:0], spi_mosi};
			end
		end
	end

endmodule

// File: source/spi_rx_if.sv
// interface from the spi receive domain to the system domain with shifter, tracker and engine modports

`timescale 1ns/1ps

interface spi_rx_if import dl_pkg::*; ();

	// last assembled byte
	// only changes on the spi_clk edge where rx_toggle flips
	byte_t rx_byte;

	// flips once per completed byte
	logic rx_toggle;

	// high while the eighth bit of a byte is on the line
	logic bit_last;

	// first byte of the current frame
	byte_t rx_cmd;

	// byte in rx_byte came after the command byte
	logic rx_payload;

	// frame in progress, low while spi_cs is high
	logic frame_open;

	// bit shifter owns the byte, its strobe and the bit position
	modport shifter_mp (
		output rx_byte,
		output rx_toggle,
		output bit_last
	);

	// frame tracker works from the bit position of the shifter
	modport tracker_mp (
		input  bit_last,
		output rx_cmd,
		output rx_payload,
		output frame_open
	);

	// system side engine reads everything but the bit position
	modport engine_mp (
		input rx_byte,
		input rx_toggle,
		input rx_cmd,
		input rx_payload,
		input frame_open
	);

endinterface

// File: source/spi_shifter.sv
// spi receive bit shifter that assembles bytes msb first and flips a strobe per byte

`timescale 1ns/1ps

module spi_shifter import dl_pkg::*; (
	input logic spi_clk,
	input logic spi_cs,
	input logic spi_mosi,
	spi_rx_if.shifter_mp rx
);

	// bit position inside the current byte
	logic [2:0] bit_cnt;
	// first seven bits of the byte, msb first
	logic [6:0] sreg;
	// local copy of the byte strobe
	logic toggle_q;
	logic last_bit;

	// eighth bit is being sampled on this edge
	assign last_bit = (bit_cnt == 3'd7);
	assign rx.bit_last = last_bit;
	assign rx.rx_toggle = toggle_q;

	// ************************************************************************
	// control state, cleared by chip select
	// ************************************************************************

	// a strobe flip caused by spi_cs is harmless
	// rx_payload clears on the same edge so the engine drops that event
	always_ff @(posedge spi_clk or posedge spi_cs) begin
		if (spi_cs) begin
			bit_cnt  <= '0;
			toggle_q <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (last_bit) begin
				toggle_q <= ~toggle_q;
			end
		end
	end

	// ************************************************************************
	// data path
	// ************************************************************************

	// byte is taken from the register plus the bit on the line
	// then held for the next eight spi_clk periods
	always_ff @(posedge spi_clk) begin
		if (last_bit) begin
			rx.rx_byte <= {sreg, spi_mosi};
		end else begin
			sreg <= {sreg[5:0], spi_mosi};
		end
	end

endmodule

// File: verif/spi_host_tasks.svh
// spi host tasks that send one byte msb first and one framed command with its payload

`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// one byte, msb first
// mosi moves while spi_clk is low, the dut samples on the rising edge
// called on a rising sck edge, returns on one with spi_clk left high
task automatic send_byte(input byte_t value);
	int i;
	for (i = 7; i >= 0; i--) begin
		spi_clk  <= 1'b0;
		spi_mosi <= value[i];
		repeat (SPI_HALF_CYCLES) @(posedge sck);
		spi_clk <= 1'b1;
		repeat (SPI_HALF_CYCLES) @(posedge sck);
	end
endtask

// whole frame: select, command byte, payload, deselect
task automatic send_frame(input byte_t cmd, input byte_t payload[$]);
	int i;
	@(posedge sck);
	spi_cs <= 1'b0;
	// setup time before the first rising spi_clk
	repeat (SPI_HALF_CYCLES) @(posedge sck);
	send_byte(cmd);
	for (i = 0; i < payload.size(); i++) begin
		send_byte(payload[i]);
	end
	spi_clk <= 1'b0;
	// last byte has to cross before chip select clears rx_payload
	repeat (FRAME_GAP_CYCLES) @(posedge sck);
	spi_cs <= 1'b1;
	// frame end reaches the engine through its synchronizer
	repeat (FRAME_GAP_CYCLES) @(posedge sck);
endtask

`endif

// File: verif/tb_data_io.sv
// download port testbench with clock, reset, spi host stimulus, scoreboard, assertions and watchdog

`timescale 1ns/1ps

module tb_data_io import dl_pkg::*; ();

	// ************************************************************************
	// timing and test sizes
	// ************************************************************************

	localparam int CLK_PERIOD_NS    = 20;
	localparam int RESET_CYCLES     = 5;
	localparam int SPI_HALF_CYCLES  = 4;
	localparam int SPI_PERIOD_NS    = 2 * SPI_HALF_CYCLES * CLK_PERIOD_NS;
	localparam int FRAME_GAP_CYCLES = 8;
	localparam int DRAIN_LIMIT      = 64;
	localparam int DATA1_BYTES      = 12;
	localparam int DATA2_BYTES      = 7;
	localparam int JUNK_BYTES       = 3;
	localparam int DATA3_BYTES      = 6;
	// not a host command the port knows
	localparam byte_t CMD_UNKNOWN   = 8'h42;

	// every byte on the wire including the command bytes
	localparam int TOTAL_BYTES = 2 + (1 + DATA1_BYTES) + (1 + DATA2_BYTES) + 2
		+ (1 + JUNK_BYTES) + 2 + (1 + DATA3_BYTES);
	localparam int WATCHDOG_NS = TOTAL_BYTES * 8 * SPI_PERIOD_NS * 2
		+ RESET_CYCLES * CLK_PERIOD_NS;

	typedef struct packed {
		addr_t addr;
		byte_t data;
	} sb_entry_t;

	logic sck, ss, spi_clk, spi_cs, spi_mosi;
	logic downloading, wr;
	addr_t size, a;
	lane_sel_t sel;
	ram_word_t d;

	// scoreboard of bytes sent and where they must land
	sb_entry_t sb_q[$];
	sb_entry_t head;
	logic head_valid;
	byte_t frame_data[$];
	addr_t exp_next;
	int seed, error_count, pushed_count, wr_count;
	string test_name;

	data_io_top DUT (.*);

	`include "spi_host_tasks.svh"

	initial begin
		sck = 1'b0;
		forever #(CLK_PERIOD_NS / 2) sck = ~sck;
	end

	// ************************************************************************
	// reporting and helpers
	// ************************************************************************

	function automatic void report_mismatch(input string what, input logic [31:0] expv,
		input logic [31:0] actv);
		$display("[ERROR] %s (%s): expected 0x%0h, actual 0x%0h", test_name, what, expv, actv);
		error_count++;
	endfunction

	function automatic void report_failure(input string msg);
		$display("[ERROR] %s: %s", test_name, msg);
		error_count++;
	endfunction

	// lane enable for a byte address
	function automatic lane_sel_t lane_for(input addr_t addr);
		case (addr[1:0])
			2'd0: return 4'b0001;
			2'd1: return 4'b0010;
			2'd2: return 4'b0100;
			default: return 4'b1000;
		endcase
	endfunction

	// random payload where booked bytes take the next expected address
	task automatic queue_data_bytes(input int count, input logic book);
		int i;
		sb_entry_t entry;
		frame_data.delete();
		for (i = 0; i < count; i++) begin
			entry.data = byte_t'($random(seed));
			entry.addr = exp_next;
			frame_data.push_back(entry.data);
			if (book) begin
				sb_q.push_back(entry);
				exp_next = exp_next + 1'b1;
				pushed_count++;
			end
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (sb_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge sck);
			cycles++;
		end
		assert (sb_q.size() == 0) else report_failure("bytes were sent but never written");
	endtask

	// status outputs compared at a falling edge
	task automatic check_state(input logic dl, input addr_t sz);
		@(negedge sck);
		assert (downloading == dl) else report_mismatch("downloading", 32'(dl), 32'(downloading));
		assert (size == sz) else report_mismatch("size", 32'(sz), 32'(size));
	endtask

	// ************************************************************************
	// scoreboard and assertions
	// ************************************************************************

	// pop on the falling edge that sees wr
	// head moves on the next rising edge
	always @(negedge sck) begin
		if (!ss && wr) begin
			wr_count++;
			if (sb_q.size() != 0) begin
				void'(sb_q.pop_front());
			end
		end
	end

	always @(posedge sck) begin
		head_valid <= (sb_q.size() != 0);
		if (sb_q.size() != 0) begin
			head <= sb_q[0];
		end
	end

	reset_state: assert property (@(negedge sck) ss |-> (!wr && !downloading && size == '0))
		else report_failure("outputs not cleared during reset");
	wr_expected: assert property (@(negedge sck) disable iff (ss) wr |-> head_valid)
		else report_failure("write pulse with no byte outstanding");
	wr_single: assert property (@(negedge sck) disable iff (ss) wr |=> !wr)
		else report_failure("write pulse longer than one cycle");
	wr_addr: assert property (@(negedge sck) disable iff (ss) wr |-> (a == head.addr))
		else report_mismatch("write address", 32'(head.addr), 32'(a));
	wr_sel: assert property (@(negedge sck) disable iff (ss) wr |-> (sel == lane_for(head.addr)))
		else report_mismatch("lane enable", 32'(lane_for(head.addr)), 32'(sel));
	wr_data: assert property (@(negedge sck) disable iff (ss) wr |-> (d == {4{head.data}}))
		else report_mismatch("write data", {4{head.data}}, d);

	// ************************************************************************
	// stimulus
	// ************************************************************************

	initial begin
		seed = 49;
		error_count = 0;
		pushed_count = 0;
		wr_count = 0;
		head_valid = 1'b0;
		head = '0;
		exp_next = START_ADDR;
		ss = 1'b1;
		spi_clk = 1'b0;
		spi_cs = 1'b0;
		spi_mosi = 1'b0;

		test_name = "reset";
		// chip select rises inside reset to clear the spi side
		@(posedge sck);
		spi_cs <= 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge sck);
		ss <= 1'b0;
		check_state(1'b0, '0);
		assert (!wr && a == '0) else report_mismatch("write address", 32'(0), 32'(a));

		test_name = "start";
		frame_data = {8'h01};
		send_frame(CMD_FILE_TX, frame_data);
		check_state(1'b1, '0);

		test_name = "data writes";
		queue_data_bytes(DATA1_BYTES, 1'b1);
		send_frame(CMD_FILE_TX_DAT, frame_data);
		wait_drain();
		check_state(1'b1, exp_next - START_ADDR);

		test_name = "split data";
		queue_data_bytes(DATA2_BYTES, 1'b1);
		send_frame(CMD_FILE_TX_DAT, frame_data);
		wait_drain();
		check_state(1'b1, exp_next - START_ADDR);

		test_name = "end";
		frame_data = {8'h00};
		send_frame(CMD_FILE_TX, frame_data);
		check_state(1'b0, exp_next - START_ADDR);
		assert (a == exp_next) else report_mismatch("next free address", 32'(exp_next), 32'(a));

		// nothing is booked so any write pulse trips wr_expected
		test_name = "unknown command";
		queue_data_bytes(JUNK_BYTES, 1'b0);
		send_frame(CMD_UNKNOWN, frame_data);
		check_state(1'b0, exp_next - START_ADDR);

		test_name = "restart";
		frame_data = {8'h3c};
		send_frame(CMD_FILE_TX, frame_data);
		exp_next = START_ADDR;
		check_state(1'b1, '0);
		queue_data_bytes(DATA3_BYTES, 1'b1);
		send_frame(CMD_FILE_TX_DAT, frame_data);
		wait_drain();
		check_state(1'b1, exp_next - START_ADDR);

		test_name = "summary";
		assert (wr_count == pushed_count)
			else report_mismatch("write pulse count", 32'(pushed_count), 32'(wr_count));
		$display("summary: %0d bytes booked, %0d write pulses, %0d errors",
			pushed_count, wr_count, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// ************************************************************************
	// watchdog
	// ************************************************************************

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, test_name);
		$display("Simulation failed");
		$finish;
	end

endmodule
